// ==== logic/dcache_pkg.sv ====
package dcache_pkg;

    localparam int xlen              = 32;
    localparam int block_bits        = 64;
    localparam int block_offset_bits = 3; // byte offset inside a line

    typedef logic [xlen-1:0]       addr_t;
    typedef logic [block_bits-1:0] block_t;
    typedef logic [31:0]           word_t;
    typedef logic [3:0]            mem_tag_t; // zero means no tag

    typedef enum logic [1:0] {BYTE, HALF, WORD} mem_size_e;
    typedef enum logic {MEM_READ, MEM_WRITE} mem_op_e;
    typedef enum logic [1:0] {BUS_NONE, BUS_LOAD, BUS_STORE} bus_cmd_e;

    // miss sequencing in the controller
    typedef enum logic [1:0] {READY, WRITE_BACK, FETCH, WAIT_FILL} dcache_state_e;

    // pipeline side
    typedef struct packed {
        logic      valid;
        mem_op_e   mem_op;
        mem_size_e size;
        addr_t     addr;
        word_t     write_content;
    } dcache_request_t;

    typedef struct packed {
        logic  valid;    // one-cycle pulse
        word_t reg_data; // zero-extended load data
    } dcache_response_t;

    // memory bus side
    typedef struct packed {
        bus_cmd_e command;
        addr_t    addr;
        block_t   data;
    } mem_request_t;

    typedef struct packed {
        mem_tag_t response; // non-zero grants the command shown this cycle
        block_t   data;
        mem_tag_t tag;      // tag of the returning load data
    } mem_response_t;

endpackage

// ==== logic/dcache_ctrl.sv ====
`timescale 1ns/10ps

module dcache_ctrl import dcache_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     request_valid,
    input  logic     hit,
    input  logic     victim_dirty,
    input  logic     granted,     // memory accepted the command shown
    input  logic     fill_ready,  // granted tag came back with data
    output logic     stall_out,
    output bus_cmd_e cmd,
    output logic     capture,
    output logic     grant_taken,
    output logic     write_hit,
    output logic     fill,
    output logic     respond
);

    dcache_state_e state;
    dcache_state_e next_state;

    // pipeline may only issue while we sit in READY
    assign stall_out = (state != READY);

    always_comb begin
        next_state  = state;
        cmd         = BUS_NONE;
        capture     = 1'b0;
        grant_taken = 1'b0;
        write_hit   = 1'b0;
        fill        = 1'b0;
        respond     = 1'b0;

        case (state)
            READY: begin
                if (request_valid) begin
                    if (hit) begin
                        respond   = 1'b1;
                        write_hit = 1'b1; // line_store only acts on it for stores
                    end else begin
                        capture    = 1'b1; // hold request and victim
                        next_state = victim_dirty ? WRITE_BACK : FETCH;
                    end
                end
            end

            WRITE_BACK: begin
                // store needs only the grant, no data comes back
                cmd = BUS_STORE;
                if (granted) begin
                    next_state = FETCH;
                end
            end

            FETCH: begin
                cmd = BUS_LOAD;
                if (granted) begin
                    grant_taken = 1'b1; // miss_buffer keeps the tag
                    next_state  = WAIT_FILL;
                end
            end

            WAIT_FILL: begin
                if (fill_ready) begin
                    fill       = 1'b1;
                    respond    = 1'b1;
                    next_state = READY;
                end
            end

            default: begin
                next_state = READY;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= READY;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== logic/line_store.sv ====
`timescale 1ns/10ps

module line_store import dcache_pkg::*; #(
    parameter int n_lines = 8
) (
    input  logic            clock,
    input  logic            reset,
    input  dcache_request_t active_request,
    input  logic            write_hit,
    input  logic            fill,
    input  block_t          merged_block,
    input  block_t          fill_block,
    output logic            hit,
    output block_t          hit_block,
    output logic            victim_dirty,
    output block_t          victim_block,
    output addr_t           victim_addr
);

    localparam int index_bits = $clog2(n_lines);
    localparam int tag_bits   = xlen - index_bits - block_offset_bits;

    typedef logic [index_bits-1:0] line_index_t;
    typedef logic [tag_bits-1:0]   line_tag_t;

    logic [n_lines-1:0] valid_bits;
    logic [n_lines-1:0] dirty_bits;
    line_tag_t          tag_array  [n_lines];
    block_t             data_array [n_lines];

    line_index_t index;
    line_tag_t   req_tag;
    logic        is_store;
    logic        line_write;
    block_t      line_data;

    assign index    = active_request.addr[block_offset_bits +: index_bits];
    assign req_tag  = active_request.addr[xlen-1 -: tag_bits];
    assign is_store = (active_request.mem_op == MEM_WRITE);

    // lookup on the indexed line
    assign hit       = active_request.valid & valid_bits[index] & (tag_array[index] == req_tag);
    assign hit_block = data_array[index];

    // the same line is the victim when the lookup misses
    assign victim_dirty = valid_bits[index] & dirty_bits[index];
    assign victim_block = data_array[index];
    assign victim_addr  = {tag_array[index], index, {block_offset_bits{1'b0}}};

    // a store hit or any fill rewrites the data
    assign line_write = fill | (write_hit & is_store);
    assign line_data  = (fill & ~is_store) ? fill_block : merged_block;

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_bits <= '0; // all lines invalid
            dirty_bits <= '0;
        end else begin
            if (fill) begin
                valid_bits[index] <= 1'b1;
                dirty_bits[index] <= is_store; // clean for a load
            end else if (write_hit & is_store) begin
                dirty_bits[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (line_write) begin
            data_array[index] <= line_data;
        end
        if (fill) begin
            tag_array[index] <= req_tag;
        end
    end

endmodule

// ==== logic/access_align.sv ====
`timescale 1ns/10ps

module access_align import dcache_pkg::*; (
    input  logic             clock,
    input  logic             reset,
    input  dcache_request_t  active_request,
    input  block_t           hit_block,
    input  block_t           fill_block,
    input  logic             fill,
    input  logic             respond,
    output block_t           merged_block,
    output dcache_response_t dcache_response
);

    block_t                       source;
    logic [block_offset_bits-1:0] offset;
    word_t                        load_data;

    assign source = fill ? fill_block : hit_block; // fresh line on a fill
    assign offset = active_request.addr[block_offset_bits-1:0];

    // store data dropped into the line by size and offset
    always_comb begin
        merged_block = source;
        case (active_request.size)
            BYTE:    merged_block[{offset, 3'b000} +: 8]        = active_request.write_content[7:0];
            HALF:    merged_block[{offset[2:1], 4'b0000} +: 16] = active_request.write_content[15:0];
            default: merged_block[{offset[2], 5'b00000} +: 32]  = active_request.write_content;
        endcase
    end

    // load extraction, zero-extended
    always_comb begin
        case (active_request.size)
            BYTE:    load_data = {24'b0, source[{offset, 3'b000} +: 8]};
            HALF:    load_data = {16'b0, source[{offset[2:1], 4'b0000} +: 16]};
            default: load_data = source[{offset[2], 5'b00000} +: 32];
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            dcache_response.valid <= 1'b0;
        end else begin
            dcache_response.valid <= respond;
        end
        // stores answer with zero
        dcache_response.reg_data <= (active_request.mem_op == MEM_READ) ? load_data : '0;
    end

endmodule

// ==== logic/miss_buffer.sv ====
`timescale 1ns/10ps

module miss_buffer import dcache_pkg::*; (
    input  logic            clock,
    input  logic            reset,
    input  dcache_request_t dcache_request,
    input  logic            capture,
    input  bus_cmd_e        cmd,
    input  logic            grant_taken,
    input  logic            fill,
    input  block_t          victim_block,
    input  addr_t           victim_addr,
    input  mem_response_t   mem_response,
    output dcache_request_t active_request,
    output logic            granted,
    output logic            fill_ready,
    output block_t          fill_block,
    output mem_request_t    mem_request
);

    logic            pending;     // a miss is held
    dcache_request_t held_request;
    addr_t           held_victim_addr;
    block_t          held_victim_block;
    mem_tag_t        held_tag;    // zero until the load is granted

    assign active_request = pending ? held_request : dcache_request;

    // a grant only counts while a command is on the bus
    assign granted    = (cmd != BUS_NONE) & (mem_response.response != '0);
    assign fill_ready = pending & (held_tag != '0) & (mem_response.tag == held_tag);
    assign fill_block = mem_response.data;

    always_comb begin
        mem_request         = '0;
        mem_request.command = cmd;
        case (cmd)
            BUS_STORE: begin
                mem_request.addr = held_victim_addr;
                mem_request.data = held_victim_block;
            end
            BUS_LOAD:  mem_request.addr = {held_request.addr[xlen-1:block_offset_bits],
                                           {block_offset_bits{1'b0}}}; // line address
            default:   mem_request.command = BUS_NONE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending  <= 1'b0;
            held_tag <= '0;
        end else begin
            if (capture) begin
                pending <= 1'b1;
            end else if (fill) begin
                pending <= 1'b0;
            end
            if (grant_taken) begin
                held_tag <= mem_response.response;
            end else if (fill) begin
                held_tag <= '0;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            held_request      <= dcache_request;
            held_victim_addr  <= victim_addr;
            held_victim_block <= victim_block;
        end
    end

endmodule

// ==== logic/dcache.sv ====
`timescale 1ns/10ps

module dcache import dcache_pkg::*; #(
    parameter int n_lines = 8
) (
    input  logic             clock,
    input  logic             reset,
    input  dcache_request_t  dcache_request,
    output dcache_response_t dcache_response,
    output logic             stall_out,
    output mem_request_t     mem_request,
    input  mem_response_t    mem_response
);

    dcache_request_t active_request;
    logic            hit;
    block_t          hit_block;
    logic            victim_dirty;
    block_t          victim_block;
    addr_t           victim_addr;
    block_t          merged_block;
    block_t          fill_block;
    logic            granted;
    logic            fill_ready;
    bus_cmd_e        cmd;
    logic            capture;
    logic            grant_taken;
    logic            write_hit;
    logic            fill;
    logic            respond;

    dcache_ctrl ctrl0 (
        .clock         (clock),
        .reset         (reset),
        .request_valid (dcache_request.valid),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .granted       (granted),
        .fill_ready    (fill_ready),
        .stall_out     (stall_out),
        .cmd           (cmd),
        .capture       (capture),
        .grant_taken   (grant_taken),
        .write_hit     (write_hit),
        .fill          (fill),
        .respond       (respond)
    );

    line_store #(.n_lines(n_lines)) store0 (
        .clock          (clock),
        .reset          (reset),
        .active_request (active_request),
        .write_hit      (write_hit),
        .fill           (fill),
        .merged_block   (merged_block),
        .fill_block     (fill_block),
        .hit            (hit),
        .hit_block      (hit_block),
        .victim_dirty   (victim_dirty),
        .victim_block   (victim_block),
        .victim_addr    (victim_addr)
    );

    access_align align0 (
        .clock           (clock),
        .reset           (reset),
        .active_request  (active_request),
        .hit_block       (hit_block),
        .fill_block      (fill_block),
        .fill            (fill),
        .respond         (respond),
        .merged_block    (merged_block),
        .dcache_response (dcache_response)
    );

    miss_buffer miss0 (
        .clock          (clock),
        .reset          (reset),
        .dcache_request (dcache_request),
        .capture        (capture),
        .cmd            (cmd),
        .grant_taken    (grant_taken),
        .fill           (fill),
        .victim_block   (victim_block),
        .victim_addr    (victim_addr),
        .mem_response   (mem_response),
        .active_request (active_request),
        .granted        (granted),
        .fill_ready     (fill_ready),
        .fill_block     (fill_block),
        .mem_request    (mem_request)
    );

endmodule

// ==== tb/dcache_sva.sv ====
`timescale 1ns/10ps

module dcache_sva import dcache_pkg::*; (
    input logic          clock,
    input logic          reset,
    input dcache_state_e state,
    input bus_cmd_e      cmd,
    input logic          granted,
    input logic          respond,
    input logic          stall_out,
    input logic          capture,
    input logic          fill
);

    // a refused command is shown again next cycle
    cmd_steady: assert property (@(posedge clock) disable iff (reset)
        (cmd != BUS_NONE && !granted) |=> (cmd == $past(cmd)))
        else $error("bus command changed before its grant");

    no_double_respond: assert property (@(posedge clock) disable iff (reset)
        respond |=> !respond)
        else $error("respond high in two cycles in a row");

    // only a captured miss leaves READY
    ready_until_capture: assert property (@(posedge clock) disable iff (reset)
        (state == READY) |=> (stall_out == $past(capture)))
        else $error("stall_out changed in READY without a captured miss");

    // only the fill ends a miss
    stall_until_fill: assert property (@(posedge clock) disable iff (reset)
        (state != READY) |=> (stall_out == !$past(fill)))
        else $error("stall_out out of step with the fill");

endmodule

bind dcache_ctrl dcache_sva sva0 (.*);

// ==== tb/dcache_tb.sv ====
`timescale 1ns/10ps

module dcache_tb import dcache_pkg::*; ();

    localparam int max_accesses = 32;
    localparam int limit        = 200; // cycles allowed for any single wait
    localparam int shadow_lines = 8;

    logic             clock;
    logic             reset;
    dcache_request_t  dcache_request;
    dcache_response_t dcache_response;
    logic             stall_out;
    mem_request_t     mem_request;
    mem_response_t    mem_response;

    logic [31:0] stim [0:5*max_accesses-1];
    block_t      mem_lines [addr_t];  // lines written back so far
    addr_t       wb_addr_q [$];
    block_t      wb_data_q [$];
    int          loads_seen;
    int          value_errors;
    int          other_errors;
    logic        timed_out;
    integer      seed;

    // shadow of the cache contents
    logic   sh_valid [shadow_lines];
    logic   sh_dirty [shadow_lines];
    addr_t  sh_addr  [shadow_lines];
    block_t sh_data  [shadow_lines];

    // memory side state
    mem_tag_t     next_tag;
    logic         load_busy;
    addr_t        load_addr;
    mem_tag_t     load_tag;
    int           load_delay;
    logic         was_refused;
    mem_request_t refused_req;

    dcache #(.n_lines(shadow_lines)) dut0 (
        .clock           (clock),
        .reset           (reset),
        .dcache_request  (dcache_request),
        .dcache_response (dcache_response),
        .stall_out       (stall_out),
        .mem_request     (mem_request),
        .mem_response    (mem_response)
    );

    always #10 clock = ~clock;

    function automatic block_t read_line(input addr_t a);
        if (mem_lines.exists(a)) begin
            return mem_lines[a];
        end
        return {a, ~a}; // untouched memory pattern
    endfunction

    // byte-wise store placement in little-endian order
    function automatic block_t place_store(input block_t blk, input mem_size_e size,
                                           input logic [2:0] offset, input word_t data);
        int     n;
        int     start;
        block_t result;
        result = blk;
        n = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        start = int'(offset) & ~(n - 1);
        for (int k = 0; k < n; k++) begin
            result[8*(start+k) +: 8] = data[8*k +: 8];
        end
        return result;
    endfunction

    task automatic compare_word(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic compare_block(input string name, input block_t actual,
                                 input block_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    task automatic compare_addr(input string name, input addr_t actual, input addr_t expected);
        if (actual !== expected) begin
            $display("** Error at %0t: %s = %h, expected %h", $time, name, actual, expected);
            value_errors++;
        end
    endtask

    // memory model with random refusals and delayed fills
    always @(posedge clock) begin
        if (reset) begin
            mem_response <= '0;
            next_tag     = 4'd1;
            load_busy    = 1'b0;
            was_refused  = 1'b0;
        end else begin
            if (was_refused) begin // refused command must be shown again unchanged
                if (mem_request.command != refused_req.command) begin
                    $display("command changed at %0t before it was granted", $time);
                    other_errors++;
                end
                compare_addr("mem_request.addr", mem_request.addr, refused_req.addr);
                compare_block("mem_request.data", mem_request.data, refused_req.data);
            end
            was_refused = (mem_request.command != BUS_NONE) && (mem_response.response == '0);
            refused_req = mem_request;

            mem_response.tag <= '0;
            if (load_busy) begin
                if (load_delay == 0) begin
                    mem_response.tag  <= load_tag;
                    mem_response.data <= read_line(load_addr);
                    load_busy = 1'b0;
                end else begin
                    load_delay--;
                end
            end

            if (mem_request.command != BUS_NONE && mem_response.response != '0) begin
                if (mem_request.command == BUS_STORE) begin
                    if (loads_seen != 0) begin
                        $display("write-back at %0t came after the line fetch", $time);
                        other_errors++;
                    end
                    wb_addr_q.push_back(mem_request.addr);
                    wb_data_q.push_back(mem_request.data);
                    mem_lines[mem_request.addr] = mem_request.data;
                end else begin
                    loads_seen++;
                    load_busy  = 1'b1;
                    load_addr  = mem_request.addr;
                    load_tag   = mem_response.response;
                    load_delay = int'({$random(seed)} % 4);
                end
                next_tag = (next_tag == 4'hf) ? 4'd1 : next_tag + 4'd1;
            end

            mem_response.response <= ({$random(seed)} % 3 == 0) ? 4'd0 : next_tag;
        end
    end

    task automatic run_access(input int n);
        dcache_request_t req;
        word_t           expected;
        addr_t           line;
        int              idx;
        int              cycles;
        logic            predict_hit;
        logic            expect_wb;
        addr_t           wb_addr_exp;
        block_t          wb_data_exp;
        req.valid         = 1'b1;
        req.mem_op        = stim[5*n][0] ? MEM_WRITE : MEM_READ;
        req.size          = mem_size_e'(stim[5*n+1][1:0]);
        req.addr          = stim[5*n+2];
        req.write_content = stim[5*n+3];
        expected          = stim[5*n+4];
        line = {req.addr[31:3], 3'b000};
        idx  = int'(req.addr[5:3]);

        // shadow prediction
        predict_hit = sh_valid[idx] && (sh_addr[idx] == line);
        expect_wb   = !predict_hit && sh_valid[idx] && sh_dirty[idx];
        wb_addr_exp = sh_addr[idx];
        wb_data_exp = sh_data[idx];
        if (!predict_hit) begin
            sh_valid[idx] = 1'b1;
            sh_dirty[idx] = 1'b0;
            sh_addr[idx]  = line;
            sh_data[idx]  = read_line(line);
        end
        if (req.mem_op == MEM_WRITE) begin
            sh_data[idx]  = place_store(sh_data[idx], req.size, req.addr[2:0],
                                        req.write_content);
            sh_dirty[idx] = 1'b1;
        end

        @(negedge clock);
        cycles = 0;
        while (stall_out && cycles < limit) begin
            @(negedge clock);
            cycles++;
        end
        if (stall_out) begin
            $display("timeout waiting for stall_out to drop before access %0d", n);
            timed_out = 1'b1;
            return;
        end
        loads_seen = 0;
        wb_addr_q.delete();
        wb_data_q.delete();

        @(posedge clock);
        dcache_request <= req;
        @(posedge clock);
        dcache_request.valid <= 1'b0;

        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!dcache_response.valid && cycles < limit);
        if (!dcache_response.valid) begin
            $display("timeout waiting for the response to access %0d", n);
            timed_out = 1'b1;
            return;
        end

        compare_word("dcache_response.reg_data", dcache_response.reg_data, expected);
        if (stall_out) begin
            $display("stall_out still high with the response to access %0d", n);
            other_errors++;
        end
        if (predict_hit && (cycles != 1 || loads_seen != 0 || wb_addr_q.size() != 0)) begin
            $display("access %0d should hit: %0d cycles, bus used", n, cycles);
            other_errors++;
        end
        if (!predict_hit) begin
            if (loads_seen != 1) begin
                $display("access %0d should fetch one line but fetched %0d", n, loads_seen);
                other_errors++;
            end else begin
                compare_addr("fetch addr", load_addr, line);
            end
        end
        if (expect_wb) begin
            if (wb_addr_q.size() != 1) begin
                $display("access %0d saw %0d write-backs instead of one", n, wb_addr_q.size());
                other_errors++;
            end else begin
                compare_addr("write-back addr", wb_addr_q[0], wb_addr_exp);
                compare_block("write-back data", wb_data_q[0], wb_data_exp);
            end
        end else if (wb_addr_q.size() != 0) begin
            $display("access %0d wrote back a clean or missing line", n);
            other_errors++;
        end
    endtask

    initial begin
        seed           = 32'h552fbdaa;
        clock          = 1'b0;
        reset          = 1'b1;
        dcache_request <= '0;
        mem_response   <= '0;
        value_errors   = 0;
        other_errors   = 0;
        loads_seen     = 0;
        timed_out      = 1'b0;
        for (int i = 0; i < shadow_lines; i++) begin
            sh_valid[i] = 1'b0;
            sh_dirty[i] = 1'b0;
            sh_addr[i]  = '0;
            sh_data[i]  = '0;
        end
        for (int i = 0; i < 5*max_accesses; i++) begin
            stim[i] = 32'hffffffff; // end marker where the file stops
        end
        $readmemh("tb/dcache_input.txt", stim);

        repeat (4) @(posedge clock);
        reset <= 1'b0;

        // idle after reset
        repeat (3) begin
            @(negedge clock);
            if (stall_out || mem_request.command != BUS_NONE || dcache_response.valid) begin
                $display("cache not idle after reset at %0t", $time);
                other_errors++;
            end
        end

        for (int n = 0; n < max_accesses; n++) begin
            if (!timed_out && stim[5*n] != 32'hffffffff) begin
                run_access(n);
            end
        end

        $display("errors: %0d value, %0d other, timeout %0d", value_errors, other_errors,
                 timed_out);
        if (value_errors == 0 && other_errors == 0 && !timed_out) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== tb/dcache_input.txt ====
// op(0 load, 1 store) size(0 byte, 1 half, 2 word) address store_data expected_load
0 2 00000100 00000000 FFFFFEFF
0 2 00000104 00000000 00000100
0 0 00000101 00000000 000000FE
0 1 00000104 00000000 00000100
1 0 00000100 000000AA 00000000
1 1 00000102 00001234 00000000
1 2 00000104 CAFEF00D 00000000
0 2 00000100 00000000 1234FEAA
0 2 00000104 00000000 CAFEF00D
0 2 00000140 00000000 FFFFFEBF
0 2 00000100 00000000 1234FEAA
0 0 00000107 00000000 000000CA
1 2 00000208 DEADBEEF 00000000
0 2 0000020C 00000000 00000208
0 2 00000208 00000000 DEADBEEF
0 1 00000248 00000000 0000FDB7
0 2 00000208 00000000 DEADBEEF
1 0 00000013 00000055 00000000
0 2 00000010 00000000 55FFFFEF

// ==== sources.f ====
logic/dcache_pkg.sv
logic/dcache_ctrl.sv
logic/line_store.sv
logic/access_align.sv
logic/miss_buffer.sv
logic/dcache.sv
tb/dcache_sva.sv
tb/dcache_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the dcache testbench with Verilator
rm -f sim.log
verilator --binary --timing --assert --top-module dcache_tb -f sources.f -o dcache_sim \
    && ./obj_dir/dcache_sim > sim.log 2>&1
cat sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1
